// File: Bender.yml
package:
  name: lcdPixelPath

sources:
  # package first, then leaf modules, then the top level.
  - design/lcdPkg.sv
  - design/videoTimer.sv
  - design/scanSequencer.sv
  - design/greenLut.sv
  - design/redBlueLut.sv
  - design/colorExpander.sv
  - design/lcdTop.sv

  - target: simulation
    files:
      - dv/lcdTb.sv

// File: design/colorExpander.sv
`timescale 1ns/1ps
`default_nettype none

module colorExpander (
	input logic clk,
	input logic rst,
	input logic pixelReq,
	input lcdPkg::rgb565T pixel,
	input lcdPkg::syncT syncIn,
	output lcdPkg::lcdOutT lcd
);

	logic capEn;
	lcdPkg::syncT syncDly;
	lcdPkg::syncT syncOut;
	logic [7:0] levelR;
	logic [7:0] levelG;
	logic [7:0] levelB;

	// source holds the pixel the cycle after its request.
	always_ff @(posedge clk) begin
		if (rst) begin
			capEn <= 1'b0;
			syncDly <= '0;
			syncOut <= '0;
		end else begin
			capEn <= pixelReq;
			syncDly <= syncIn;
			syncOut <= syncDly; // lines up with the lut outputs.
		end
	end

	greenLut gLut (.clk(clk), .clkEn(capEn), .code(pixel.green), .level(levelG));
	redBlueLut rLut (.clk(clk), .clkEn(capEn), .code(pixel.red), .level(levelR));
	redBlueLut bLut (.clk(clk), .clkEn(capEn), .code(pixel.blue), .level(levelB));

	always_comb begin
		lcd.sync = syncOut;
		lcd.rgb = '0; // black in blanking.
		if (syncOut.de) begin
			lcd.rgb.red = levelR;
			lcd.rgb.green = levelG;
			lcd.rgb.blue = levelB;
		end
	end

endmodule

`default_nettype wire

// File: design/greenLut.sv
`timescale 1ns/1ps
`default_nettype none

module greenLut (
	input logic clk,
	input logic clkEn,
	input logic [5:0] code,
	output logic [7:0] level
);

	// perceptual tone curve, steep at the ends.
	always_ff @(posedge clk) begin
		if (clkEn) begin
			case (code)
				6'h00: level <= 8'h00;
				6'h01: level <= 8'h06;
				6'h02: level <= 8'h0C;
				6'h03: level <= 8'h11;
				6'h04: level <= 8'h17;
				6'h05: level <= 8'h1B;
				6'h06: level <= 8'h1F;
				6'h07: level <= 8'h22;
				6'h08: level <= 8'h25;
				6'h09: level <= 8'h28;
				6'h0A: level <= 8'h2A;
				6'h0B: level <= 8'h2C;
				6'h0C: level <= 8'h2E;
				6'h0D: level <= 8'h2F;
				6'h0E: level <= 8'h31;
				6'h0F: level <= 8'h32;
				6'h10: level <= 8'h34;
				6'h11: level <= 8'h35;
				6'h12: level <= 8'h37;
				6'h13: level <= 8'h38;
				6'h14: level <= 8'h39;
				6'h15: level <= 8'h3A;
				6'h16: level <= 8'h3B;
				6'h17: level <= 8'h3C;
				6'h18: level <= 8'h3D;
				6'h19: level <= 8'h3D;
				6'h1A: level <= 8'h3E;
				6'h1B: level <= 8'h3F;
				6'h1C: level <= 8'h40;
				6'h1D: level <= 8'h41;
				6'h1E: level <= 8'h42;
				6'h1F: level <= 8'h43;
				6'h20: level <= 8'h44;
				6'h21: level <= 8'h45;
				6'h22: level <= 8'h46;
				6'h23: level <= 8'h47;
				6'h24: level <= 8'h48;
				6'h25: level <= 8'h49;
				6'h26: level <= 8'h4A;
				6'h27: level <= 8'h4B;
				6'h28: level <= 8'h4C;
				6'h29: level <= 8'h4D;
				6'h2A: level <= 8'h4E;
				6'h2B: level <= 8'h4F;
				6'h2C: level <= 8'h4F;
				6'h2D: level <= 8'h50;
				6'h2E: level <= 8'h51;
				6'h2F: level <= 8'h52;
				6'h30: level <= 8'h53;
				6'h31: level <= 8'h53;
				6'h32: level <= 8'h54;
				6'h33: level <= 8'h55;
				6'h34: level <= 8'h55;
				6'h35: level <= 8'h56;
				6'h36: level <= 8'h57;
				6'h37: level <= 8'h58;
				6'h38: level <= 8'h58;
				6'h39: level <= 8'h59;
				6'h3A: level <= 8'h5A;
				6'h3B: level <= 8'h5A;
				6'h3C: level <= 8'h5B;
				6'h3D: level <= 8'h5D;
				6'h3E: level <= 8'h61;
				6'h3F: level <= 8'h67;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcdPkg.sv
`default_nettype none

package lcdPkg;

	// clock cycles per pixel period.
	localparam int PIX_DIV = 2;

	// horizontal timing in pixel periods.
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical timing in lines.
	localparam int V_ACTIVE = 6;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int H_BITS = 5;
	localparam int V_BITS = 4;

	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565T;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888T;

	// all active high.
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} syncT;

	typedef struct packed {
		syncT sync;
		rgb888T rgb;
	} lcdOutT;

endpackage

`default_nettype wire

// File: design/lcdTop.sv
`timescale 1ns/1ps
`default_nettype none

module lcdTop (
	input logic clk,
	input logic rst,
	input logic run,
	input lcdPkg::rgb565T pixel,
	output logic pixelReq,
	output logic frameDone,
	output lcdPkg::lcdOutT lcd
);

	logic timerClear;
	logic pixEn;
	logic [lcdPkg::H_BITS-1:0] hCount;
	logic [lcdPkg::V_BITS-1:0] vCount;
	lcdPkg::syncT sync;

	videoTimer timer (
		.clk(clk),
		.rst(rst),
		.clear(timerClear),
		.pixEn(pixEn),
		.hCount(hCount),
		.vCount(vCount)
	);

	scanSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.run(run),
		.pixEn(pixEn),
		.hCount(hCount),
		.vCount(vCount),
		.timerClear(timerClear),
		.sync(sync),
		.pixelReq(pixelReq),
		.frameDone(frameDone)
	);

	colorExpander expander (
		.clk(clk),
		.rst(rst),
		.pixelReq(pixelReq),
		.pixel(pixel),
		.syncIn(sync),
		.lcd(lcd)
	);

endmodule

`default_nettype wire

// File: design/redBlueLut.sv
`timescale 1ns/1ps
`default_nettype none

module redBlueLut (
	input logic clk,
	input logic clkEn,
	input logic [4:0] code,
	output logic [7:0] level
);

	// same curve as green, every second entry.
	always_ff @(posedge clk) begin
		if (clkEn) begin
			case (code)
				5'h00: level <= 8'h00;
				5'h01: level <= 8'h0C;
				5'h02: level <= 8'h17;
				5'h03: level <= 8'h1F;
				5'h04: level <= 8'h25;
				5'h05: level <= 8'h2A;
				5'h06: level <= 8'h2E;
				5'h07: level <= 8'h31;
				5'h08: level <= 8'h34;
				5'h09: level <= 8'h37;
				5'h0A: level <= 8'h39;
				5'h0B: level <= 8'h3B;
				5'h0C: level <= 8'h3D;
				5'h0D: level <= 8'h3E;
				5'h0E: level <= 8'h40;
				5'h0F: level <= 8'h42;
				5'h10: level <= 8'h44;
				5'h11: level <= 8'h46;
				5'h12: level <= 8'h48;
				5'h13: level <= 8'h4A;
				5'h14: level <= 8'h4C;
				5'h15: level <= 8'h4E;
				5'h16: level <= 8'h4F;
				5'h17: level <= 8'h51;
				5'h18: level <= 8'h53;
				5'h19: level <= 8'h54;
				5'h1A: level <= 8'h55;
				5'h1B: level <= 8'h57;
				5'h1C: level <= 8'h58;
				5'h1D: level <= 8'h5A;
				5'h1E: level <= 8'h5B;
				5'h1F: level <= 8'h61;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/scanSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scanSequencer (
	input logic clk,
	input logic rst,
	input logic run,
	input logic pixEn,
	input logic [lcdPkg::H_BITS-1:0] hCount,
	input logic [lcdPkg::V_BITS-1:0] vCount,
	output logic timerClear,
	output lcdPkg::syncT sync,
	output logic pixelReq,
	output logic frameDone
);

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		FINISH
	} stateT;

	stateT state;

	logic frameWrap;
	logic activeNow;
	logic hsyncNow;
	logic vsyncNow;

	// pixEn on the last position of the frame.
	assign frameWrap = pixEn && (hCount == lcdPkg::H_TOTAL - 1)
		&& (vCount == lcdPkg::V_TOTAL - 1);

	assign activeNow = (hCount < lcdPkg::H_ACTIVE) && (vCount < lcdPkg::V_ACTIVE);
	assign hsyncNow = (hCount >= lcdPkg::H_ACTIVE + lcdPkg::H_FRONT)
		&& (hCount < lcdPkg::H_ACTIVE + lcdPkg::H_FRONT + lcdPkg::H_SYNC);
	assign vsyncNow = (vCount >= lcdPkg::V_ACTIVE + lcdPkg::V_FRONT)
		&& (vCount < lcdPkg::V_ACTIVE + lcdPkg::V_FRONT + lcdPkg::V_SYNC);

	assign timerClear = state == IDLE; // timer parked while idle.

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			sync <= '0;
			pixelReq <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			pixelReq <= 1'b0;
			frameDone <= frameWrap && (state != IDLE);

			// region decode, one step per pixel period.
			if (state != IDLE && pixEn) begin
				sync.hsync <= hsyncNow;
				sync.vsync <= vsyncNow;
				sync.de <= activeNow;
				pixelReq <= activeNow;
			end

			case (state)
				IDLE: begin
					sync <= '0;
					if (run) begin
						state <= SCAN;
					end
				end
				SCAN: begin
					if (frameWrap) begin
						state <= run ? SCAN : IDLE;
					end else if (!run) begin
						state <= FINISH; // let the frame run out.
					end
				end
				FINISH: begin
					if (frameWrap) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/videoTimer.sv
`timescale 1ns/1ps
`default_nettype none

module videoTimer (
	input logic clk,
	input logic rst,
	input logic clear,
	output logic pixEn,
	output logic [lcdPkg::H_BITS-1:0] hCount,
	output logic [lcdPkg::V_BITS-1:0] vCount
);

	logic [$clog2(lcdPkg::PIX_DIV)-1:0] divCnt;
	logic divLast;
	logic hLast;
	logic vLast;

	assign divLast = divCnt == lcdPkg::PIX_DIV - 1;
	assign hLast = hCount == lcdPkg::H_TOTAL - 1;
	assign vLast = vCount == lcdPkg::V_TOTAL - 1;

	// pixel rate divider.
	// pixEn is registered, so the first pulse lands PIX_DIV cycles after clear drops.
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			divCnt <= '0;
			pixEn <= 1'b0;
		end else begin
			pixEn <= divLast;
			if (divLast) begin
				divCnt <= '0;
			end else begin
				divCnt <= divCnt + 1'b1;
			end
		end
	end

	// position counters.
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			hCount <= '0;
			vCount <= '0;
		end else if (pixEn) begin
			if (hLast) begin
				hCount <= '0;
				if (vLast) begin
					vCount <= '0; // end of frame.
				end else begin
					vCount <= vCount + 1'b1;
				end
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/lcdTb.sv
`timescale 1ns/1ps
`default_nettype none

module lcdTb;

	localparam int CLK_PERIOD = 8;
	localparam logic [31:0] SEED = 32'he1e5_deee;
	localparam int FRAME_CYCLES = lcdPkg::V_TOTAL * lcdPkg::H_TOTAL * lcdPkg::PIX_DIV;
	localparam int IDLE_CYCLES = FRAME_CYCLES / 4;
	localparam int TEST_FRAMES = 6; // idle, four scanned frames, quiet tail.
	localparam int WATCHDOG_NS = (TEST_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;
	localparam int DE_CYCLES = lcdPkg::H_ACTIVE * lcdPkg::PIX_DIV;
	localparam int HS_CYCLES = lcdPkg::H_SYNC * lcdPkg::PIX_DIV;
	localparam int HS_OFFSET = (lcdPkg::H_ACTIVE + lcdPkg::H_FRONT) * lcdPkg::PIX_DIV;
	localparam int VS_CYCLES = lcdPkg::V_SYNC * lcdPkg::H_TOTAL * lcdPkg::PIX_DIV;
	localparam int REQ_PER_FRAME = lcdPkg::V_ACTIVE * lcdPkg::H_ACTIVE;

	// reference tone curve, 6-bit code to 8-bit level.
	localparam logic [7:0] GREEN_CURVE [64] = '{
		8'h00, 8'h06, 8'h0C, 8'h11, 8'h17, 8'h1B, 8'h1F, 8'h22,
		8'h25, 8'h28, 8'h2A, 8'h2C, 8'h2E, 8'h2F, 8'h31, 8'h32,
		8'h34, 8'h35, 8'h37, 8'h38, 8'h39, 8'h3A, 8'h3B, 8'h3C,
		8'h3D, 8'h3D, 8'h3E, 8'h3F, 8'h40, 8'h41, 8'h42, 8'h43,
		8'h44, 8'h45, 8'h46, 8'h47, 8'h48, 8'h49, 8'h4A, 8'h4B,
		8'h4C, 8'h4D, 8'h4E, 8'h4F, 8'h4F, 8'h50, 8'h51, 8'h52,
		8'h53, 8'h53, 8'h54, 8'h55, 8'h55, 8'h56, 8'h57, 8'h58,
		8'h58, 8'h59, 8'h5A, 8'h5A, 8'h5B, 8'h5D, 8'h61, 8'h67
	};

	logic clk = 1'b0;
	logic rst;
	logic run;
	lcdPkg::rgb565T pixel;
	logic pixelReq;
	logic frameDone;
	lcdPkg::lcdOutT lcd;

	string testName = "reset";
	int errorCount = 0;
	int errorsAtStart = 0;
	int passCount = 0;
	int failCount = 0;
	logic quietOn;
	lcdPkg::rgb888T expQ [$];
	lcdPkg::rgb888T expRgb;
	logic popDue;
	logic [6:0] sweepIdx;

	logic deWas;
	logic hsWas;
	logic deLine;
	logic doneArmed;
	int deRun;
	int hsRun;
	int sinceDe;
	int reqCount;
	int vsCount;
	int deLines;
	int sinceDone;

	lcdTop dut (
		.clk(clk),
		.rst(rst),
		.run(run),
		.pixel(pixel),
		.pixelReq(pixelReq),
		.frameDone(frameDone),
		.lcd(lcd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// red and blue use every second green entry.
	function automatic lcdPkg::rgb888T expandPixel(lcdPkg::rgb565T p);
		lcdPkg::rgb888T e;
		e.red = GREEN_CURVE[2 * p.red];
		e.green = GREEN_CURVE[p.green];
		e.blue = GREEN_CURVE[2 * p.blue];
		return e;
	endfunction

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
	endtask

	task automatic endTest();
		if (errorCount == errorsAtStart) begin
			passCount++;
			$display("test %s: ok", testName);
		end else begin
			failCount++;
			$display("test %s: FAILED with %0d errors", testName, errorCount - errorsAtStart);
		end
	endtask

	task automatic waitFrameDone();
		do @(negedge clk); while (!frameDone);
	endtask

	// pixel source, directed sweep of all codes first.
	initial begin
		logic [31:0] rnd;
		lcdPkg::rgb565T nextPix;
		void'($urandom(SEED));
		forever begin
			@(negedge clk);
			if (rst) begin
				popDue = 1'b0;
				sweepIdx = '0;
			end else begin
				if (popDue) expRgb <= expQ.pop_front(); // ready for the check a cycle later.
				popDue = pixelReq;
				if (pixelReq) begin
					if (!sweepIdx[6]) begin
						nextPix.red = sweepIdx[4:0];
						nextPix.green = sweepIdx[5:0];
						nextPix.blue = ~sweepIdx[4:0];
						sweepIdx = sweepIdx + 1'b1;
					end else begin
						rnd = $urandom;
						nextPix = rnd[15:0];
					end
					pixel = nextPix;
					expQ.push_back(expandPixel(nextPix));
				end
			end
		end
	end

	// line and frame bookkeeping on the panel side.
	always @(negedge clk) begin
		if (rst) begin
			{deWas, hsWas, deLine, doneArmed} <= '0;
			{deRun, hsRun, sinceDe, reqCount, vsCount, deLines, sinceDone} <= '0;
		end else begin
			deWas <= lcd.sync.de;
			hsWas <= lcd.sync.hsync;
			deRun <= lcd.sync.de ? deRun + 1 : 0;
			hsRun <= lcd.sync.hsync ? hsRun + 1 : 0;
			if (lcd.sync.de && !deWas) begin
				sinceDe <= 1;
				deLine <= 1'b1;
			end else begin
				sinceDe <= sinceDe + 1;
				if (lcd.sync.hsync && !hsWas) deLine <= 1'b0;
			end
			if (frameDone) begin
				{reqCount, vsCount, deLines} <= '0;
				sinceDone <= 1;
				doneArmed <= 1'b1;
			end else begin
				reqCount <= reqCount + int'(pixelReq);
				vsCount <= vsCount + int'(lcd.sync.vsync);
				deLines <= deLines + int'(lcd.sync.de && !deWas);
				sinceDone <= sinceDone + 1;
			end
		end
	end

	quietOutputs: assert property (@(negedge clk) disable iff (rst)
		quietOn |-> (lcd == '0 && !pixelReq && !frameDone))
		else begin
			errorCount++;
			$display("FAIL %s: quiet outputs expected 0, actual lcd %h req %b done %b",
				testName, $sampled(lcd), $sampled(pixelReq), $sampled(frameDone));
		end

	deWidth: assert property (@(negedge clk) disable iff (rst)
		(deWas && !lcd.sync.de) |-> (deRun == DE_CYCLES))
		else begin
			errorCount++;
			$display("FAIL %s: de cycles expected %0d, actual %0d",
				testName, DE_CYCLES, $sampled(deRun));
		end

	hsyncWidth: assert property (@(negedge clk) disable iff (rst)
		(hsWas && !lcd.sync.hsync) |-> (hsRun == HS_CYCLES))
		else begin
			errorCount++;
			$display("FAIL %s: hsync cycles expected %0d, actual %0d",
				testName, HS_CYCLES, $sampled(hsRun));
		end

	hsyncStart: assert property (@(negedge clk) disable iff (rst)
		(lcd.sync.hsync && !hsWas && deLine) |-> (sinceDe == HS_OFFSET))
		else begin
			errorCount++;
			$display("FAIL %s: hsync offset from de expected %0d, actual %0d",
				testName, HS_OFFSET, $sampled(sinceDe));
		end

	colourMatch: assert property (@(negedge clk) disable iff (rst)
		pixelReq |-> ##2 (lcd.sync.de && lcd.rgb == expRgb))
		else begin
			errorCount++;
			$display("FAIL %s: colour expected %h, actual %h de %b",
				testName, $sampled(expRgb), $sampled(lcd.rgb), $sampled(lcd.sync.de));
		end

	frameCounts: assert property (@(negedge clk) disable iff (rst)
		frameDone |-> (reqCount == REQ_PER_FRAME && vsCount == VS_CYCLES
			&& deLines == lcdPkg::V_ACTIVE))
		else begin
			errorCount++;
			$display("FAIL %s: req/vsync/de lines expected %0d/%0d/%0d, actual %0d/%0d/%0d",
				testName, REQ_PER_FRAME, VS_CYCLES, lcdPkg::V_ACTIVE,
				$sampled(reqCount), $sampled(vsCount), $sampled(deLines));
		end

	framePeriod: assert property (@(negedge clk) disable iff (rst)
		(frameDone && doneArmed) |-> (sinceDone == FRAME_CYCLES))
		else begin
			errorCount++;
			$display("FAIL %s: frame period expected %0d, actual %0d",
				testName, FRAME_CYCLES, $sampled(sinceDone));
		end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the scan stalled and the tests did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		run = 1'b0;
		pixel = '0;
		quietOn = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		startTest("idleAfterReset");
		quietOn = 1'b1;
		repeat (IDLE_CYCLES) @(negedge clk);
		quietOn = 1'b0;
		endTest();
		startTest("directedSweep");
		run = 1'b1;
		waitFrameDone();
		endTest();
		startTest("lineTiming");
		waitFrameDone();
		endTest();
		startTest("frameTiming");
		waitFrameDone();
		endTest();
		startTest("stopMidFrame");
		repeat (FRAME_CYCLES / 3) @(negedge clk);
		run = 1'b0;
		waitFrameDone(); // frame still runs out.
		quietOn = 1'b1;
		repeat (FRAME_CYCLES) @(negedge clk);
		quietOn = 1'b0;
		endTest();
		$display("tests passed %0d, failed %0d, assertion errors %0d",
			passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
design/lcdPkg.sv
design/videoTimer.sv
design/scanSequencer.sv
design/greenLut.sv
design/redBlueLut.sv
design/colorExpander.sv
design/lcdTop.sv
dv/lcdTb.sv
